//--- verilog/fetch_pkg.sv
package fetch_pkg;

    localparam int xlen        = 32;
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = 2;

    // states of the request stage
    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_waiting  = 2'd1;
    localparam logic [1:0] st_decoding = 2'd2;
    localparam logic [1:0] st_stopped  = 2'd3;

    // major opcodes that change control flow
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // compressed encodings, matched as {funct3, op}
    localparam logic [4:0] c_jal  = 5'b001_01;
    localparam logic [4:0] c_j    = 5'b101_01;
    localparam logic [4:0] c_beqz = 5'b110_01;
    localparam logic [4:0] c_bnez = 5'b111_01;
    localparam logic [4:0] c_cr   = 5'b100_10;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } full_fields_t;

    // body holds bits 12..2, where the compressed immediates are scattered
    typedef struct packed {
        logic [15:0] upper;
        logic [2:0]  funct3;
        logic [10:0] body;
        logic [1:0]  op;
    } comp_fields_t;

    typedef union packed {
        full_fields_t full;
        comp_fields_t c;
    } insn_word_t;

    typedef enum logic [1:0] {seq, jump, branch, indirect} cf_class_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        insn_word_t      word;
        logic            compressed;
        cf_class_t       cls;
        logic [xlen-1:0] offset;
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        insn_word_t      word;
        logic            compressed;
    } fetch_entry_t;

endpackage

//--- verilog/fetch_request.sv
`timescale 1ns/10ps

module fetch_request (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       redirect,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    input  logic                       queue_room,
    input  logic                       pred_valid,
    input  logic [fetch_pkg::xlen-1:0] pred_pc,
    input  logic                       mem_valid,
    input  logic [fetch_pkg::xlen-1:0] mem_data,
    output logic                       mem_req,
    output logic [fetch_pkg::xlen-1:0] mem_addr,
    output logic                       resp_valid,
    output fetch_pkg::insn_word_t      resp_word,
    output logic [fetch_pkg::xlen-1:0] resp_pc
);

    logic [1:0]                 state;
    logic [fetch_pkg::xlen-1:0] fetch_pc;
    logic                       stale;

    // a response is passed on only when it answers the current fetch pc
    assign resp_valid = mem_valid && (state == fetch_pkg::st_waiting) && !stale;
    assign resp_word  = mem_data;
    assign resp_pc    = fetch_pc;
    assign mem_addr   = fetch_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_pkg::st_idle;
            fetch_pc <= '0;
            stale    <= 1'b0;
            mem_req  <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            if (redirect) begin
                fetch_pc <= redirect_pc;
                if ((state == fetch_pkg::st_waiting) && !mem_valid) begin
                    // the old request is still out, so its answer must be swallowed
                    stale <= 1'b1;
                end else begin
                    stale <= 1'b0;
                    state <= fetch_pkg::st_idle;
                end
            end else begin
                case (state)
                    fetch_pkg::st_idle: begin
                        if (queue_room) begin
                            mem_req <= 1'b1;
                            state   <= fetch_pkg::st_waiting;
                        end
                    end
                    fetch_pkg::st_waiting: begin
                        if (mem_valid) begin
                            stale <= 1'b0;
                            state <= stale ? fetch_pkg::st_idle : fetch_pkg::st_decoding;
                        end
                    end
                    fetch_pkg::st_decoding: begin
                        // no prediction means an indirect jump, wait for the back end
                        if (!pred_valid) begin
                            state <= fetch_pkg::st_stopped;
                        end else if (queue_room) begin
                            fetch_pc <= pred_pc;
                            mem_req  <= 1'b1;
                            state    <= fetch_pkg::st_waiting;
                        end else begin
                            fetch_pc <= pred_pc;
                            state    <= fetch_pkg::st_idle;
                        end
                    end
                    default: begin
                        state <= fetch_pkg::st_stopped;
                    end
                endcase
            end
        end
    end

endmodule

//--- verilog/fetch_predecode.sv
`timescale 1ns/10ps

module fetch_predecode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       redirect,
    input  logic                       resp_valid,
    input  fetch_pkg::insn_word_t      resp_word,
    input  logic [fetch_pkg::xlen-1:0] resp_pc,
    output logic                       dec_valid,
    output fetch_pkg::decoded_t        dec
);

    fetch_pkg::decoded_t        dec_next;
    logic                       compressed;
    fetch_pkg::cf_class_t       cls;
    logic [fetch_pkg::xlen-1:0] offset;
    logic [fetch_pkg::xlen-1:0] j_imm;
    logic [fetch_pkg::xlen-1:0] b_imm;
    logic [fetch_pkg::xlen-1:0] cj_imm;
    logic [fetch_pkg::xlen-1:0] cb_imm;
    logic [10:0]                body;

    assign body = resp_word.c.body;

    // anything other than 11 in the low bits is a 16 bit instruction
    assign compressed = (resp_word.c.op != 2'b11);

    assign j_imm = {{12{resp_word.full.funct7[6]}},
                    resp_word.full.rs1,
                    resp_word.full.funct3,
                    resp_word.full.rs2[0],
                    resp_word.full.funct7[5:0],
                    resp_word.full.rs2[4:1],
                    1'b0};

    assign b_imm = {{20{resp_word.full.funct7[6]}},
                    resp_word.full.rd[0],
                    resp_word.full.funct7[5:0],
                    resp_word.full.rd[4:1],
                    1'b0};

    // body index k is instruction bit k+2
    assign cj_imm = {{21{body[10]}}, body[6], body[8:7], body[4], body[5],
                     body[0], body[9], body[3:1], 1'b0};

    assign cb_imm = {{24{body[10]}}, body[4:3], body[0], body[9:8], body[2:1], 1'b0};

    always_comb begin
        cls    = fetch_pkg::seq;
        offset = '0;
        if (!compressed) begin
            case (resp_word.full.opcode)
                fetch_pkg::op_jal: begin
                    cls    = fetch_pkg::jump;
                    offset = j_imm;
                end
                fetch_pkg::op_branch: begin
                    cls    = fetch_pkg::branch;
                    offset = b_imm;
                end
                fetch_pkg::op_jalr: begin
                    cls = fetch_pkg::indirect;
                end
                default: begin
                    cls = fetch_pkg::seq;
                end
            endcase
        end else begin
            case ({resp_word.c.funct3, resp_word.c.op})
                fetch_pkg::c_j, fetch_pkg::c_jal: begin
                    cls    = fetch_pkg::jump;
                    offset = cj_imm;
                end
                fetch_pkg::c_beqz, fetch_pkg::c_bnez: begin
                    cls    = fetch_pkg::branch;
                    offset = cb_imm;
                end
                fetch_pkg::c_cr: begin
                    // c.jr and c.jalr have rs2 zero and rs1 non-zero
                    if ((body[4:0] == 5'd0) && (body[9:5] != 5'd0)) begin
                        cls = fetch_pkg::indirect;
                    end
                end
                default: begin
                    cls = fetch_pkg::seq;
                end
            endcase
        end
    end

    assign dec_next.pc         = resp_pc;
    assign dec_next.word       = resp_word;
    assign dec_next.compressed = compressed;
    assign dec_next.cls        = cls;
    assign dec_next.offset     = offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= resp_valid && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_valid) begin
            dec <= dec_next;
        end
    end

endmodule

//--- verilog/fetch_predict.sv
`timescale 1ns/10ps

module fetch_predict (
    input  logic                       dec_valid,
    input  fetch_pkg::decoded_t        dec,
    output logic                       pred_valid,
    output logic [fetch_pkg::xlen-1:0] pred_pc
);

    logic [fetch_pkg::xlen-1:0] seq_pc;
    logic [fetch_pkg::xlen-1:0] target_pc;

    // fall through by the length of the instruction
    assign seq_pc = dec.pc + (dec.compressed ? 32'd2 : 32'd4);

    assign target_pc = dec.pc + dec.offset;

    // every direct branch is predicted taken
    always_comb begin
        pred_valid = dec_valid;
        pred_pc    = seq_pc;
        case (dec.cls)
            fetch_pkg::jump, fetch_pkg::branch: begin
                pred_pc = target_pc;
            end
            fetch_pkg::indirect: begin
                // the target lives in a register, only the back end knows it
                pred_valid = 1'b0;
            end
            default: begin
                pred_pc = seq_pc;
            end
        endcase
    end

endmodule

//--- verilog/fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   redirect,
    input  logic                   dec_valid,
    input  fetch_pkg::decoded_t    dec,
    input  logic                   iq_full,
    output logic                   queue_room,
    output logic                   issue_valid,
    output fetch_pkg::fetch_entry_t issue_entry
);

    fetch_pkg::fetch_entry_t          entries [fetch_pkg::queue_depth];
    logic [fetch_pkg::queue_ptr_w-1:0] head;
    logic [fetch_pkg::queue_ptr_w-1:0] tail;
    logic [fetch_pkg::queue_ptr_w:0]   count;
    logic                              push;
    logic                              pop;

    assign push = dec_valid;
    assign pop  = issue_valid && !iq_full;

    assign issue_valid = (count != '0);
    assign issue_entry = entries[head];

    // two free slots, one for the instruction already in flight
    assign queue_room = (count <= (fetch_pkg::queue_ptr_w + 1)'(fetch_pkg::queue_depth - 2));

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tail] <= '{pc: dec.pc, word: dec.word, compressed: dec.compressed};
        end
    end

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       mem_req,
    output logic [fetch_pkg::xlen-1:0] mem_addr,
    input  logic                       mem_valid,
    input  logic [fetch_pkg::xlen-1:0] mem_data,
    input  logic                       redirect,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    output logic                       issue_valid,
    output fetch_pkg::fetch_entry_t    issue_entry,
    input  logic                       iq_full
);

    logic                       resp_valid;
    fetch_pkg::insn_word_t      resp_word;
    logic [fetch_pkg::xlen-1:0] resp_pc;
    logic                       dec_valid;
    fetch_pkg::decoded_t        dec;
    logic                       pred_valid;
    logic [fetch_pkg::xlen-1:0] pred_pc;
    logic                       queue_room;

    fetch_request i_request (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .queue_room  (queue_room),
        .pred_valid  (pred_valid),
        .pred_pc     (pred_pc),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .resp_valid  (resp_valid),
        .resp_word   (resp_word),
        .resp_pc     (resp_pc)
    );

    fetch_predecode i_predecode (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .resp_valid (resp_valid),
        .resp_word  (resp_word),
        .resp_pc    (resp_pc),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    fetch_predict i_predict (
        .dec_valid  (dec_valid),
        .dec        (dec),
        .pred_valid (pred_valid),
        .pred_pc    (pred_pc)
    );

    fetch_queue i_queue (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .iq_full     (iq_full),
        .queue_room  (queue_room),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry)
    );

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb;

    logic                    clk;
    logic                    rst;
    logic                    mem_req;
    logic [31:0]             mem_addr;
    logic                    mem_valid;
    logic [31:0]             mem_data;
    logic                    redirect;
    logic [31:0]             redirect_pc;
    logic                    issue_valid;
    fetch_pkg::fetch_entry_t issue_entry;
    logic                    iq_full;

    // halfword memory, indexed by address bits 8..1
    logic [15:0] mem [256];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_word [$];
    logic        exp_c [$];
    int          redir_cnt [$];
    logic [31:0] redir_pc [$];
    int          issued;
    int          n_exp;
    int          delay;
    int          quiet;
    logic        after_indirect;
    logic        pending;
    logic        loaded;
    logic [31:0] req_addr;

    fetch_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .issue_valid (issue_valid),
        .issue_entry (issue_entry),
        .iq_full     (iq_full)
    );

    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // jalr, c.jr and c.jalr take their target from a register
    function automatic logic is_indirect(input logic [31:0] word, input logic c);
        if (c) begin
            return (word[15:13] == 3'b100) && (word[1:0] == 2'b10) &&
                   (word[6:2] == 5'd0) && (word[11:7] != 5'd0);
        end
        return (word[6:0] == 7'b1100111);
    endfunction

    task automatic load_tests;
        int          fd;
        int          code;
        int          c;
        string       kind;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verification/fetch_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file verification/fetch_tests.txt");
            $display("TEST FAIL");
            $fatal(1, "missing test file");
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), ~8'(i)};
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "mem") begin
                code = $fscanf(fd, "%h %h", a, b);
                mem[a[7:0]] = b[15:0];
            end else if (kind == "exp") begin
                code = $fscanf(fd, "%h %h %d", a, b, c);
                exp_pc.push_back(a);
                exp_word.push_back(b);
                exp_c.push_back(c != 0);
            end else if (kind == "redir") begin
                code = $fscanf(fd, "%d %h", c, a);
                redir_cnt.push_back(c);
                redir_pc.push_back(a);
            end else begin
                code = $fgets(line, fd);
            end
        end
        $fclose(fd);
    endtask

    // memory answers every request after 1 to 4 cycles with two halfwords
    always @(negedge clk) begin
        mem_valid = 1'b0;
        if (mem_req) begin
            check_value(32'(pending), 32'd0, "request while another is outstanding");
            pending  = 1'b1;
            req_addr = mem_addr;
            delay    = $urandom_range(4, 1);
        end
        if (pending) begin
            if (delay == 0) begin
                mem_valid = 1'b1;
                mem_data  = {mem[req_addr[8:1] + 8'd1], mem[req_addr[8:1]]};
                pending   = 1'b0;
            end else begin
                delay = delay - 1;
            end
        end
    end

    initial begin
        wait (loaded);
        #(n_exp * 200 * 40);
        $display("the expected issue stream did not finish before the watchdog expired");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        mem_valid      = 1'b0;
        mem_data       = '0;
        redirect       = 1'b0;
        redirect_pc    = '0;
        iq_full        = 1'b0;
        issued         = 0;
        quiet          = 0;
        after_indirect = 1'b0;
        pending        = 1'b0;
        delay          = 0;
        req_addr       = '0;
        loaded         = 1'b0;
        void'($urandom(32'h2221_2eb7));
        load_tests();
        n_exp  = exp_pc.size();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (issued < n_exp) begin
            @(negedge clk);
            redirect = 1'b0;
            iq_full  = ($urandom_range(3) == 0);
            if ((redir_cnt.size() > 0) && (issued == redir_cnt[0])) begin
                if (after_indirect && (quiet < 12)) begin
                    // fetch stays stopped behind the indirect jump, longer than one fetch
                    check_value(32'(issue_valid), 32'd0, "issue_valid before redirect");
                    quiet = quiet + 1;
                end else begin
                    // hold issue off so nothing is consumed in the flush cycle
                    redirect    = 1'b1;
                    redirect_pc = redir_pc.pop_front();
                    iq_full     = 1'b1;
                    quiet       = 0;
                    void'(redir_cnt.pop_front());
                end
            end else if (issue_valid && !iq_full) begin
                check_value(issue_entry.pc, exp_pc[0], "pc");
                check_value(32'(issue_entry.compressed), 32'(exp_c[0]), "compressed");
                check_value(32'(issue_entry.word) & (exp_c[0] ? 32'h0000ffff : 32'hffffffff),
                            exp_word[0], "word");
                after_indirect = is_indirect(exp_word[0], exp_c[0]);
                void'(exp_pc.pop_front());
                void'(exp_word.pop_front());
                void'(exp_c.pop_front());
                issued = issued + 1;
            end
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- vlog.f
verilog/fetch_pkg.sv
verilog/fetch_request.sv
verilog/fetch_predecode.sv
verilog/fetch_predict.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
verification/fetch_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = fetch_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/fetch_tests.txt
# mem <halfword address> <value> | exp <pc> <word> <compressed>
# redir <issued count> <target pc>, all numbers hex except the count and the flag
mem 00 8093
mem 01 0010
mem 02 0085
mem 03 8093
mem 04 0010
mem 05 410d
mem 06 006f
mem 07 0140
mem 10 a021
mem 14 0463
mem 15 0000
mem 18 0085
mem 19 dc7d
mem 20 0001
mem 21 8067
mem 22 0000
mem 24 0085
mem 25 8082
mem 28 8082
mem 30 8093
mem 31 0010
mem 32 f06f
mem 33 fe5f
mem 38 e099
mem 3b 8093
mem 3c 0010
mem 3d 8067
mem 3e 0000
exp 00000000 00108093 0
exp 00000004 00000085 1
exp 00000006 00108093 0
exp 0000000a 0000410d 1
exp 0000000c 0140006f 0
exp 00000020 0000a021 1
exp 00000028 00000463 0
exp 00000030 00000085 1
exp 00000032 0000dc7d 1
exp 00000030 00000085 1
exp 00000032 0000dc7d 1
exp 00000040 00000001 1
exp 00000042 00008067 0
exp 00000050 00008082 1
exp 00000060 00108093 0
exp 00000064 fe5ff06f 0
exp 00000048 00000085 1
exp 0000004a 00008082 1
exp 00000070 0000e099 1
exp 00000076 00108093 0
exp 0000007a 00008067 0
redir 11 00000040
redir 13 00000050
redir 14 00000060
redir 18 00000070
